/* src/fsab_pkg.sv */
`default_nettype none

package fsab_pkg;

	// Bus widths
	localparam int FSAB_DATA_W = 32;     // Data word
	localparam int FSAB_ADDR_W = 32;     // Byte address
	localparam int FSAB_DID_W  = 2;      // Device id

	localparam int FSAB_DEVICES = 3;     // Requesters on the arbiter

	// Device ids, also the arbiter slots
	localparam logic [FSAB_DID_W-1:0] DID_PRELOAD = 2'd0;
	localparam logic [FSAB_DID_W-1:0] DID_IFETCH  = 2'd1;
	localparam logic [FSAB_DID_W-1:0] DID_DATA    = 2'd2;

	// Request mode
	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_t;

	// Read response, broadcast from memory to all requesters
	typedef struct packed {
		logic                   valid;  // One cycle per read
		logic [FSAB_DID_W-1:0]  did;    // Requester that asked
		logic [FSAB_DATA_W-1:0] data;   // Read word
	} fsab_rsp_t;

	// Defaults for the top level
	localparam int FSAB_CREDITS_DEF = 4;   // Memory queue slots
	localparam int MEM_AW_DEF       = 10;  // 1024 words

endpackage

`default_nettype wire

/* src/fsab_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fsab_req_if;

	logic                               valid;  // Request present
	fsab_pkg::fsab_mode_t               mode;   // Read or write
	logic [fsab_pkg::FSAB_DID_W-1:0]   did;    // Requesting device
	logic [fsab_pkg::FSAB_ADDR_W-1:0]  addr;   // Byte address
	logic [fsab_pkg::FSAB_DATA_W-1:0]  data;   // Write data
	logic                               grant;  // Transfer cycle

	// Requester side, holds fields until grant
	modport requester (
		output valid, mode, did, addr, data,
		input  grant
	);

	// Arbiter side of a requester link
	modport arbiter (
		input  valid, mode, did, addr, data,
		output grant
	);

	// Arbiter to memory, one-cycle pulses, no grant
	modport source (
		output valid, mode, did, addr, data
	);

	modport sink (
		input  valid, mode, did, addr, data
	);

endinterface

`default_nettype wire

/* src/fsab_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module fsab_arbiter #(
	parameter int CREDITS = fsab_pkg::FSAB_CREDITS_DEF
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        credit,                          // Memory retired one request
	fsab_req_if.arbiter req [fsab_pkg::FSAB_DEVICES],
	fsab_req_if.source  mem
);

	localparam int N     = fsab_pkg::FSAB_DEVICES;
	localparam int CNT_W = $clog2(CREDITS + 1);
	localparam int IDX_W = $clog2(N);

	logic [N-1:0]                       valids;       // Gathered request lines
	fsab_pkg::fsab_mode_t               modes [N];
	logic [fsab_pkg::FSAB_DID_W-1:0]   dids  [N];
	logic [fsab_pkg::FSAB_ADDR_W-1:0]  addrs [N];
	logic [fsab_pkg::FSAB_DATA_W-1:0]  datas [N];
	logic [N-1:0]                       grants;
	logic [CNT_W-1:0]                   credit_cnt;   // Free memory queue slots
	logic [IDX_W-1:0]                   last;         // Last winner
	logic [IDX_W-1:0]                   win;          // Winner this cycle
	logic                               found;        // Some requester valid
	logic                               fire;         // Forward to memory

	// Flatten the interface array
	genvar g;
	generate
		for (g = 0; g < N; g++) begin : gather
			assign valids[g]    = req[g].valid;
			assign modes[g]     = req[g].mode;
			assign dids[g]      = req[g].did;
			assign addrs[g]     = req[g].addr;
			assign datas[g]     = req[g].data;
			assign req[g].grant = grants[g];
		end
	endgenerate

	// Round robin, search starts just after last winner
	always_comb begin : pick
		int idx;
		win   = last;
		found = 1'b0;
		for (int k = 1; k <= N; k++) begin
			idx = (int'(last) + k) % N;
			if (!found && valids[idx]) begin
				win   = IDX_W'(idx);
				found = 1'b1;
			end
		end
	end

	assign fire = found && (credit_cnt != '0);  // Never spend a missing credit

	always_comb begin
		grants = '0;
		if (fire)
			grants[win] = 1'b1;  // Grant same cycle as forward
	end

	// Winner fields straight onto the memory link
	assign mem.valid = fire;
	assign mem.mode  = modes[win];
	assign mem.did   = dids[win];
	assign mem.addr  = addrs[win];
	assign mem.data  = datas[win];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credit_cnt <= CNT_W'(CREDITS);  // Full queue available
			last       <= IDX_W'(N - 1);     // Slot 0 first
		end else begin
			credit_cnt <= credit_cnt - CNT_W'(fire) + CNT_W'(credit);
			if (fire)
				last <= win;
		end
	end

endmodule

`default_nettype wire

/* src/fsab_sim_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module fsab_sim_memory #(
	parameter int CREDITS = fsab_pkg::FSAB_CREDITS_DEF,
	parameter int MEM_AW  = fsab_pkg::MEM_AW_DEF
) (
	input  logic                clk,
	input  logic                rst_n,
	fsab_req_if.sink            req,
	output logic                credit,  // One per retired request
	output fsab_pkg::fsab_rsp_t rsp
);

	localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
	localparam int CNT_W = $clog2(CREDITS + 1);
	localparam int WORDS = 2 ** MEM_AW;

	// Request queue, one slot per credit
	fsab_pkg::fsab_mode_t               q_mode [CREDITS];
	logic [fsab_pkg::FSAB_DID_W-1:0]   q_did  [CREDITS];
	logic [fsab_pkg::FSAB_ADDR_W-1:0]  q_addr [CREDITS];
	logic [fsab_pkg::FSAB_DATA_W-1:0]  q_data [CREDITS];

	logic [fsab_pkg::FSAB_DATA_W-1:0]  words  [WORDS];  // Backing store

	logic [PTR_W-1:0]                   wr_ptr;
	logic [PTR_W-1:0]                   rd_ptr;
	logic [CNT_W-1:0]                   q_count;
	logic                               push;
	logic                               pop;
	logic [MEM_AW-1:0]                  head_idx;  // Word index of queue head
	logic                               rsp_valid;
	logic [fsab_pkg::FSAB_DID_W-1:0]   rsp_did;
	logic [fsab_pkg::FSAB_DATA_W-1:0]  rsp_data;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(CREDITS - 1)) ? '0 : p + 1'b1;  // Wrap at depth
	endfunction

	// Unloaded words read back as zero
	initial begin
		for (int i = 0; i < WORDS; i++)
			words[i] = '0;
	end

	assign push     = req.valid;               // Arbiter holds a credit for it
	assign pop      = (q_count != '0);         // Retire one per cycle
	assign head_idx = q_addr[rd_ptr][MEM_AW+1:2];  // Drop byte offset

	always_ff @(posedge clk) begin
		if (push) begin
			q_mode[wr_ptr] <= req.mode;
			q_did[wr_ptr]  <= req.did;
			q_addr[wr_ptr] <= req.addr;
			q_data[wr_ptr] <= req.data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			q_count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			q_count <= q_count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	// Store on write retirement
	always @(posedge clk) begin
		if (pop && q_mode[rd_ptr] == fsab_pkg::FSAB_WRITE)
			words[head_idx] <= q_data[rd_ptr];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credit    <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			credit    <= pop;  // Reads and writes both return a credit
			rsp_valid <= pop && (q_mode[rd_ptr] == fsab_pkg::FSAB_READ);
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			rsp_did  <= q_did[rd_ptr];  // Tag for the port match
			rsp_data <= words[head_idx];
		end
	end

	assign rsp = '{valid: rsp_valid, did: rsp_did, data: rsp_data};

endmodule

`default_nettype wire

/* src/fsab_preload.sv */
`timescale 1ns/1ps
`default_nettype none

module fsab_preload #(
	parameter int CREDITS = fsab_pkg::FSAB_CREDITS_DEF
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              load_valid,
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] load_addr,
	input  logic [fsab_pkg::FSAB_DATA_W-1:0] load_data,
	input  logic                              load_done,   // Image complete
	output logic                              load_full,
	input  logic                              credit,      // Shared with arbiter
	fsab_req_if.requester                     bus,
	output logic                              core_rst_n
);

	localparam int CNT_W = $clog2(CREDITS + 1);

	logic [fsab_pkg::FSAB_ADDR_W-1:0] buf_addr [2];  // Two-entry load queue
	logic [fsab_pkg::FSAB_DATA_W-1:0] buf_data [2];
	logic                              wr_sel;
	logic                              rd_sel;
	logic [1:0]                        buf_count;
	logic                              push;
	logic                              pop;
	logic                              ret;          // Write credit back
	logic [CNT_W-1:0]                  outstanding;  // Granted, not yet retired
	logic                              done_seen;

	assign load_full = (buf_count == 2'd2);
	assign push      = load_valid && !load_full;
	assign pop       = bus.grant;
	assign ret       = credit && (outstanding != '0);  // Ignore read credits later

	// Head of queue goes out as a write
	assign bus.valid = (buf_count != 2'd0);
	assign bus.mode  = fsab_pkg::FSAB_WRITE;
	assign bus.did   = fsab_pkg::DID_PRELOAD;
	assign bus.addr  = buf_addr[rd_sel];
	assign bus.data  = buf_data[rd_sel];

	always_ff @(posedge clk) begin
		if (push) begin
			buf_addr[wr_sel] <= load_addr;
			buf_data[wr_sel] <= load_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_sel      <= 1'b0;
			rd_sel      <= 1'b0;
			buf_count   <= 2'd0;
			outstanding <= '0;
			done_seen   <= 1'b0;
			core_rst_n  <= 1'b0;  // Core held during load
		end else begin
			if (push)
				wr_sel <= ~wr_sel;
			if (pop)
				rd_sel <= ~rd_sel;
			buf_count   <= buf_count + 2'(push) - 2'(pop);
			outstanding <= outstanding + CNT_W'(pop) - CNT_W'(ret);
			if (load_done)
				done_seen <= 1'b1;
			if (done_seen && buf_count == 2'd0 && outstanding == '0)
				core_rst_n <= 1'b1;  // Every write retired
		end
	end

endmodule

`default_nettype wire

/* src/fsab_read_port.sv */
`timescale 1ns/1ps
`default_nettype none

module fsab_read_port #(
	parameter logic [fsab_pkg::FSAB_DID_W-1:0] DID = fsab_pkg::DID_IFETCH
) (
	input  logic                              clk,
	input  logic                              rst_n,    // System and core reset
	input  logic                              rd_req,   // One-cycle strobe
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] rd_addr,
	output logic                              rd_wait,
	output logic [fsab_pkg::FSAB_DATA_W-1:0] rd_data,
	fsab_req_if.requester                     bus,
	input  fsab_pkg::fsab_rsp_t               rsp
);

	typedef enum logic [1:0] {
		ST_IDLE,  // Ready for rd_req
		ST_REQ,   // Valid up, waiting on grant
		ST_WAIT   // Granted, waiting on response
	} state_t;

	state_t                            state;
	logic [fsab_pkg::FSAB_ADDR_W-1:0] req_addr;  // Latched read address
	logic                              match;     // Response is ours

	assign match = rsp.valid && (rsp.did == DID);

	assign bus.valid = (state == ST_REQ);
	assign bus.mode  = fsab_pkg::FSAB_READ;
	assign bus.did   = DID;
	assign bus.addr  = req_addr;
	assign bus.data  = '0;  // Reads carry no data

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			rd_wait <= 1'b1;  // Busy while core is held
		end else begin
			case (state)
				ST_IDLE: begin
					if (rd_req && !rd_wait) begin
						state   <= ST_REQ;
						rd_wait <= 1'b1;
					end else begin
						rd_wait <= 1'b0;
					end
				end
				ST_REQ: begin
					if (bus.grant)
						state <= ST_WAIT;  // Fields held until here
				end
				ST_WAIT: begin
					if (match) begin
						state   <= ST_IDLE;
						rd_wait <= 1'b0;  // Data valid next cycle
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && rd_req && !rd_wait)
			req_addr <= rd_addr;
		if (state == ST_WAIT && match)
			rd_data <= rsp.data;  // Held until the next read
	end

endmodule

`default_nettype wire

/* src/fsab_system.sv */
`timescale 1ns/1ps
`default_nettype none

module fsab_system #(
	parameter int CREDITS = fsab_pkg::FSAB_CREDITS_DEF,
	parameter int MEM_AW  = fsab_pkg::MEM_AW_DEF
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              load_valid,   // Preload word strobe
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] load_addr,
	input  logic [fsab_pkg::FSAB_DATA_W-1:0] load_data,
	input  logic                              load_done,
	output logic                              load_full,
	output logic                              core_rst_n,
	input  logic                              ic_rd_req,    // Instruction fetch port
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] ic_rd_addr,
	output logic                              ic_rd_wait,
	output logic [fsab_pkg::FSAB_DATA_W-1:0] ic_rd_data,
	input  logic                              dc_rd_req,    // Data read port
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] dc_rd_addr,
	output logic                              dc_rd_wait,
	output logic [fsab_pkg::FSAB_DATA_W-1:0] dc_rd_data
);

	fsab_req_if req_bus [fsab_pkg::FSAB_DEVICES] ();  // Slot per device id
	fsab_req_if mem_bus ();                            // Arbiter to memory

	logic                mem_credit;  // Retirement pulse
	fsab_pkg::fsab_rsp_t mem_rsp;     // Broadcast responses
	logic                port_rst_n;  // Ports wait for image

	assign port_rst_n = rst_n & core_rst_n;

	fsab_preload #(.CREDITS(CREDITS)) preload (
		.clk        (clk),
		.rst_n      (rst_n),
		.load_valid (load_valid),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.load_done  (load_done),
		.load_full  (load_full),
		.credit     (mem_credit),
		.bus        (req_bus[fsab_pkg::DID_PRELOAD]),
		.core_rst_n (core_rst_n)
	);

	fsab_read_port #(.DID(fsab_pkg::DID_IFETCH)) ifetch (
		.clk     (clk),
		.rst_n   (port_rst_n),
		.rd_req  (ic_rd_req),
		.rd_addr (ic_rd_addr),
		.rd_wait (ic_rd_wait),
		.rd_data (ic_rd_data),
		.bus     (req_bus[fsab_pkg::DID_IFETCH]),
		.rsp     (mem_rsp)
	);

	fsab_read_port #(.DID(fsab_pkg::DID_DATA)) dport (
		.clk     (clk),
		.rst_n   (port_rst_n),
		.rd_req  (dc_rd_req),
		.rd_addr (dc_rd_addr),
		.rd_wait (dc_rd_wait),
		.rd_data (dc_rd_data),
		.bus     (req_bus[fsab_pkg::DID_DATA]),
		.rsp     (mem_rsp)
	);

	fsab_arbiter #(.CREDITS(CREDITS)) arbiter (
		.clk    (clk),
		.rst_n  (rst_n),
		.credit (mem_credit),
		.req    (req_bus),
		.mem    (mem_bus)
	);

	fsab_sim_memory #(.CREDITS(CREDITS), .MEM_AW(MEM_AW)) mem (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (mem_bus),
		.credit (mem_credit),
		.rsp    (mem_rsp)
	);

endmodule

`default_nettype wire

/* sim/fsab_system_props.sv */
`timescale 1ns/1ps
`default_nettype none

module fsab_system_props #(
	parameter int CREDITS = fsab_pkg::FSAB_CREDITS_DEF,
	parameter int N       = fsab_pkg::FSAB_DEVICES
) (
	input logic                              clk,
	input logic                              rst_n,
	input logic                              fire,        // Forward to memory
	input logic                              credit,      // Memory retirement pulse
	input logic [$clog2(CREDITS+1)-1:0]      credit_cnt,
	input logic [N-1:0]                      valids,
	input logic [N-1:0]                      grants,
	input fsab_pkg::fsab_mode_t              modes [N],
	input logic [fsab_pkg::FSAB_DID_W-1:0]  dids  [N],
	input logic [fsab_pkg::FSAB_ADDR_W-1:0] addrs [N],
	input logic [fsab_pkg::FSAB_DATA_W-1:0] datas [N]
);

	int fails = 0;  // Failed assertions so far
	int inflight;   // Forwarded, credit not yet back

	always_ff @(posedge clk) begin
		if (!rst_n)
			inflight <= 0;
		else
			inflight <= inflight + int'(fire) - int'(credit);
	end

	// Memory queue must have a free slot
	a_no_credit: assert property (@(posedge clk) disable iff (!rst_n)
		fire |-> inflight < CREDITS)
		else begin
			$error("Forward issued with every credit in use");
			fails++;
		end

	a_cnt_max: assert property (@(posedge clk) disable iff (!rst_n) int'(credit_cnt) <= CREDITS)
		else begin
			$error("Credit count above queue depth");
			fails++;
		end

	for (genvar i = 0; i < N; i++) begin : per_req
		// Slot index is the device id
		a_grant_valid: assert property (@(posedge clk) disable iff (!rst_n)
			grants[i] |-> valids[i] && int'(dids[i]) == i)
			else begin
				$error("Grant without valid or with foreign did on slot %0d", i);
				fails++;
			end

		// Waiting requester keeps everything still
		a_hold: assert property (@(posedge clk) disable iff (!rst_n)
			valids[i] && !grants[i] |=> valids[i] && $stable(addrs[i]) && $stable(dids[i])
				&& $stable(modes[i]) && $stable(datas[i]))
			else begin
				$error("Request on slot %0d changed before grant", i);
				fails++;
			end
	end

endmodule

bind fsab_arbiter fsab_system_props #(.CREDITS(CREDITS), .N(N)) props (
	.clk        (clk),
	.rst_n      (rst_n),
	.fire       (fire),
	.credit     (credit),
	.credit_cnt (credit_cnt),
	.valids     (valids),
	.grants     (grants),
	.modes      (modes),
	.dids       (dids),
	.addrs      (addrs),
	.datas      (datas)
);

`default_nettype wire

/* sim/fsab_system_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fsab_system_tb;

	localparam int N_LOAD  = 8;
	localparam int N_RD    = 13;
	localparam int TIMEOUT = 200;  // Cycles allowed per wait

	logic        clk = 1'b0;
	logic        rst_n;
	logic        load_valid;
	logic [31:0] load_addr;
	logic [31:0] load_data;
	logic        load_done;
	logic        load_full;
	logic        core_rst_n;
	logic        ic_rd_req;
	logic [31:0] ic_rd_addr;
	logic        ic_rd_wait;
	logic [31:0] ic_rd_data;
	logic        dc_rd_req;
	logic [31:0] dc_rd_addr;
	logic        dc_rd_wait;
	logic [31:0] dc_rd_data;

	int   seed;
	int   errors;
	int   timeouts;
	int   asrt_fails;
	logic done_sent;  // load_done already driven

	logic [31:0] ld_addr    [N_LOAD];  // Load image
	logic [31:0] ld_data    [N_LOAD];
	logic [1:0]  rd_sel     [N_RD];    // Bit 0 ifetch, bit 1 data
	logic [31:0] rd_ic_addr [N_RD];
	logic [31:0] rd_ic_exp  [N_RD];
	logic [31:0] rd_dc_addr [N_RD];
	logic [31:0] rd_dc_exp  [N_RD];

	fsab_system #(
		.CREDITS (fsab_pkg::FSAB_CREDITS_DEF),
		.MEM_AW  (fsab_pkg::MEM_AW_DEF)
	) UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.load_valid (load_valid),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.load_done  (load_done),
		.load_full  (load_full),
		.core_rst_n (core_rst_n),
		.ic_rd_req  (ic_rd_req),
		.ic_rd_addr (ic_rd_addr),
		.ic_rd_wait (ic_rd_wait),
		.ic_rd_data (ic_rd_data),
		.dc_rd_req  (dc_rd_req),
		.dc_rd_addr (dc_rd_addr),
		.dc_rd_wait (dc_rd_wait),
		.dc_rd_data (dc_rd_data)
	);

	always #10 clk = ~clk;  // 20 ns period

	// Core stays held, ports busy, until the image is complete
	always @(negedge clk) begin
		if (rst_n && !core_rst_n && !(ic_rd_wait && dc_rd_wait)) begin
			errors++;
			$display("ERR @%0t: rd_wait low while core held in reset", $time);
		end
		if (rst_n && core_rst_n && !done_sent) begin
			errors++;
			$display("ERR @%0t: core_rst_n released before load_done", $time);
		end
	end

	task automatic set_read(input int i, input logic [1:0] sel, input logic [31:0] ia,
			input logic [31:0] ie, input logic [31:0] da, input logic [31:0] de);
		rd_sel[i]     = sel;
		rd_ic_addr[i] = ia;
		rd_ic_exp[i]  = ie;
		rd_dc_addr[i] = da;
		rd_dc_exp[i]  = de;
	endtask

	task automatic build_tables();
		for (int k = 0; k < N_LOAD; k++) begin
			ld_addr[k] = 32'h40 + 32'(k * 12);  // Word aligned, spread out
			ld_data[k] = $unsigned($random(seed));
		end
		for (int k = 0; k < N_LOAD; k++)
			set_read(k, 2'b01, ld_addr[k], ld_data[k], 32'h0, 32'h0);
		set_read(8, 2'b10, 32'h0, 32'h0, ld_addr[2], ld_data[2]);
		set_read(9, 2'b10, 32'h0, 32'h0, ld_addr[5], ld_data[5]);
		set_read(10, 2'b10, 32'h0, 32'h0, 32'h800, 32'h0);  // Never loaded
		set_read(11, 2'b11, ld_addr[7], ld_data[7], ld_addr[0], ld_data[0]);
		set_read(12, 2'b11, ld_addr[3], ld_data[3], 32'hFFC, 32'h0);  // Same-cycle pair
	endtask

	task automatic timed_out(input string what);
		timeouts++;
		$display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
	endtask

	task automatic check_word(input string port, input int idx, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR @%0t: %s read %0d got %h expected %h", $time, port, idx, got, exp);
		end
	endtask

	task automatic run_test();
		int cnt;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (int k = 0; k < N_LOAD; k++) begin
			cnt = 0;
			@(negedge clk);
			while (load_full && cnt < TIMEOUT) begin  // Only drive into free space
				@(negedge clk);
				cnt++;
			end
			if (load_full) begin
				timed_out("load buffer space");
				return;
			end
			@(posedge clk);
			load_valid <= 1'b1;
			load_addr  <= ld_addr[k];
			load_data  <= ld_data[k];
			@(posedge clk);
			load_valid <= 1'b0;
		end
		@(posedge clk);
		load_done <= 1'b1;
		done_sent = 1'b1;
		@(posedge clk);
		load_done <= 1'b0;
		cnt = 0;
		while (!core_rst_n && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!core_rst_n) begin
			timed_out("core reset release");
			return;
		end
		if (load_full !== 1'b0) begin  // Buffer drained before release
			errors++;
			$display("ERR @%0t: load_full high after preload finished", $time);
		end
		cnt = 0;
		while ((ic_rd_wait || dc_rd_wait) && cnt < TIMEOUT) begin  // Ports come out idle
			@(negedge clk);
			cnt++;
		end
		if (ic_rd_wait || dc_rd_wait) begin
			timed_out("read ports to go idle");
			return;
		end
		for (int i = 0; i < N_RD; i++) begin
			@(posedge clk);
			ic_rd_req  <= rd_sel[i][0];
			ic_rd_addr <= rd_ic_addr[i];
			dc_rd_req  <= rd_sel[i][1];
			dc_rd_addr <= rd_dc_addr[i];
			@(posedge clk);
			ic_rd_req <= 1'b0;
			dc_rd_req <= 1'b0;
			@(negedge clk);
			if ((rd_sel[i][0] && !ic_rd_wait) || (rd_sel[i][1] && !dc_rd_wait)) begin
				errors++;
				$display("ERR @%0t: rd_wait not high after read %0d", $time, i);
			end
			cnt = 0;
			while (((rd_sel[i][0] && ic_rd_wait) || (rd_sel[i][1] && dc_rd_wait))
					&& cnt < TIMEOUT) begin
				@(negedge clk);
				cnt++;
			end
			if ((rd_sel[i][0] && ic_rd_wait) || (rd_sel[i][1] && dc_rd_wait)) begin
				timed_out("read response");
				return;
			end
			if (rd_sel[i][0])
				check_word("ifetch", i, ic_rd_data, rd_ic_exp[i]);
			if (rd_sel[i][1])
				check_word("data", i, dc_rd_data, rd_dc_exp[i]);
		end
	endtask

	initial begin
		seed       = 10;
		errors     = 0;
		timeouts   = 0;
		done_sent  = 1'b0;
		rst_n      = 1'b0;
		load_valid = 1'b0;
		load_addr  = '0;
		load_data  = '0;
		load_done  = 1'b0;
		ic_rd_req  = 1'b0;
		ic_rd_addr = '0;
		dc_rd_req  = 1'b0;
		dc_rd_addr = '0;
		build_tables();
		run_test();
		repeat (2) @(posedge clk);
		asrt_fails = UUT.arbiter.props.fails;
		$display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
			errors, timeouts, asrt_fails);
		if (errors == 0 && timeouts == 0 && asrt_fails == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* fsab_system.f */
src/fsab_pkg.sv
src/fsab_req_if.sv
src/fsab_arbiter.sv
src/fsab_sim_memory.sv
src/fsab_preload.sv
src/fsab_read_port.sv
src/fsab_system.sv
sim/fsab_system_props.sv
sim/fsab_system_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = fsab_system_tb
FILELIST = fsab_system.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = *** TEST FAILED ***
PASS_MSG = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
